/* project.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_agu.sv
src/lsu_dcache.sv
src/lsu_ex.sv
src/lsu_top.sv
verification/lsu_clk_gen.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and exits non-zero unless it passed.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f --top-module lsu_tb -o lsu_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/lsu_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" <<< "$output"; then
    exit 0
fi
exit 1

/* src/lsu_agu.sv */
// Address generation stage; adds base and immediate and registers the operation.
`include "lsu_params.svh"

module lsu_agu
    import lsu_pkg::*;
(
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_valid,
    input  lsu_func_t                       i_lsu_func,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_base,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_imm,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0]   i_tag,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_lq_select,
    input  logic [`LSU_SQ_DEPTH-1:0]        i_sq_select,
    input  logic                            i_retire,
    input  logic [`LSU_DATA_WIDTH-1:0]      i_store_data,
    input  logic [`LSU_DC_LINE_WIDTH-1:0]   i_fill_line,

    output logic                            o_valid,
    output lsu_func_t                       o_lsu_func,
    output dc_addr_t                        o_addr,
    output logic [`LSU_ROB_IDX_WIDTH-1:0]   o_tag,
    output logic [`LSU_LQ_DEPTH-1:0]        o_lq_select,
    output logic [`LSU_SQ_DEPTH-1:0]        o_sq_select,
    output logic                            o_retire,
    output logic [`LSU_DATA_WIDTH-1:0]      o_store_data,
    output logic [`LSU_DC_LINE_WIDTH-1:0]   o_fill_line
);

    always_ff @(posedge clk) begin
        if (~n_rst) o_valid <= 1'b0;
        else        o_valid <= i_valid;
    end

    always_ff @(posedge clk) begin
        o_lsu_func   <= i_lsu_func;
        o_addr.flat  <= i_base + i_imm;  // Effective address.
        o_tag        <= i_tag;
        o_lq_select  <= i_lq_select;
        o_sq_select  <= i_sq_select;
        o_retire     <= i_retire;
        o_store_data <= i_store_data;
        o_fill_line  <= i_fill_line;
    end

endmodule

/* src/lsu_dcache.sv */
// Direct-mapped write-back data cache with a registered lookup stage for the LSU pipeline.
`include "lsu_params.svh"

module lsu_dcache
    import lsu_pkg::*;
(
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_valid,
    input  lsu_func_t                       i_lsu_func,
    input  dc_addr_t                        i_addr,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0]   i_tag,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_lq_select,
    input  logic [`LSU_SQ_DEPTH-1:0]        i_sq_select,
    input  logic                            i_retire,
    input  logic [`LSU_DATA_WIDTH-1:0]      i_store_data,
    input  logic [`LSU_DC_LINE_WIDTH-1:0]   i_fill_line,

    output logic                            o_valid,
    output lsu_func_t                       o_lsu_func,
    output dc_addr_t                        o_addr,
    output logic [`LSU_ROB_IDX_WIDTH-1:0]   o_tag,
    output logic [`LSU_LQ_DEPTH-1:0]        o_lq_select,
    output logic [`LSU_SQ_DEPTH-1:0]        o_sq_select,
    output logic                            o_retire,
    output logic                            o_hit,
    output logic [`LSU_DATA_WIDTH-1:0]      o_data,
    output logic                            o_victim_valid,
    output logic                            o_victim_dirty,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_victim_addr,
    output logic [`LSU_DC_LINE_WIDTH-1:0]   o_victim_data
);

    logic [`LSU_DC_TAG_WIDTH-1:0]   tag_q  [`LSU_DC_SETS];
    logic [`LSU_DC_LINE_WIDTH-1:0]  data_q [`LSU_DC_SETS];
    logic [`LSU_DC_SETS-1:0]        valid_q;
    logic [`LSU_DC_SETS-1:0]        dirty_q;

    logic [`LSU_DC_INDEX_WIDTH-1:0] index;
    logic [`LSU_DC_LINE_WIDTH-1:0]  line;
    logic                           hit;
    logic [`LSU_DATA_WIDTH-1:0]     word;
    logic [`LSU_DATA_WIDTH-1:0]     load_data;
    logic                           is_store;
    logic [`LSU_DC_LINE_SIZE-1:0]   byte_en;
    logic [`LSU_DATA_WIDTH-1:0]     store_word;
    logic [`LSU_DC_LINE_WIDTH-1:0]  merged_line;
    logic                           fill_en;
    logic                           store_en;

    assign index     = i_addr.fields.index;
    assign line      = data_q[index];
    assign hit       = valid_q[index] & (tag_q[index] == i_addr.fields.tag);
    assign word      = line[i_addr.fields.offset[`LSU_DC_OFFSET_WIDTH-1:2]*`LSU_DATA_WIDTH
                            +: `LSU_DATA_WIDTH];
    assign load_data = word >> {i_addr.fields.offset[1:0], 3'b000};  // Byte or half to bit 0.

    assign is_store   = (i_lsu_func == SB) | (i_lsu_func == SH) | (i_lsu_func == SW);
    assign store_word = i_store_data << {i_addr.fields.offset[1:0], 3'b000};
    assign fill_en    = i_valid & (i_lsu_func == FILL);
    assign store_en   = i_valid & is_store & i_retire & hit;  // Merge only at retire.

    always_comb begin
        case (i_lsu_func)
            SB:      byte_en = {{(`LSU_DC_LINE_SIZE-1){1'b0}}, 1'b1} << i_addr.fields.offset;
            SH:      byte_en = {{(`LSU_DC_LINE_SIZE-2){1'b0}}, 2'b11} << i_addr.fields.offset;
            SW:      byte_en = {{(`LSU_DC_LINE_SIZE-4){1'b0}}, 4'hf} << i_addr.fields.offset;
            default: byte_en = '0;
        endcase
    end

    always_comb begin
        merged_line = line;
        for (int b = 0; b < `LSU_DC_LINE_SIZE; b++) begin
            if (byte_en[b]) begin
                merged_line[b*8 +: 8] = store_word[(b % (`LSU_DATA_WIDTH/8))*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;  // Fresh line from memory.
        end else if (store_en) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[index]  <= i_addr.fields.tag;
            data_q[index] <= i_fill_line;
        end else if (store_en) begin
            data_q[index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (~n_rst) o_valid <= 1'b0;
        else        o_valid <= i_valid;
    end

    // Victim fields show the line as it was before this operation.
    always_ff @(posedge clk) begin
        o_lsu_func     <= i_lsu_func;
        o_addr         <= i_addr;
        o_tag          <= i_tag;
        o_lq_select    <= i_lq_select;
        o_sq_select    <= i_sq_select;
        o_retire       <= i_retire;
        o_hit          <= hit;
        o_data         <= load_data;
        o_victim_valid <= valid_q[index];
        o_victim_dirty <= dirty_q[index];
        o_victim_addr  <= {tag_q[index], index, {`LSU_DC_OFFSET_WIDTH{1'b0}}};
        o_victim_data  <= line;
    end

endmodule

/* src/lsu_ex.sv */
// Execute stage of the LSU; extends loads, drives the CDB, queue updates and victim enqueue.
`include "lsu_params.svh"

module lsu_ex
    import lsu_pkg::*;
(
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    input  logic                            i_valid,
    input  lsu_func_t                       i_lsu_func,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_lq_select,
    input  logic [`LSU_SQ_DEPTH-1:0]        i_sq_select,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0]   i_tag,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_addr,
    input  logic                            i_retire,

    input  logic                            i_dc_hit,
    input  logic [`LSU_DATA_WIDTH-1:0]      i_dc_data,
    input  logic                            i_dc_victim_valid,
    input  logic                            i_dc_victim_dirty,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_dc_victim_addr,
    input  logic [`LSU_DC_LINE_WIDTH-1:0]   i_dc_victim_data,

    output logic                            o_valid,
    output logic [`LSU_DATA_WIDTH-1:0]      o_data,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_addr,
    output logic [`LSU_ROB_IDX_WIDTH-1:0]   o_tag,

    output logic                            o_update_lq_en,
    output logic [`LSU_LQ_DEPTH-1:0]        o_update_lq_select,
    output logic                            o_update_lq_retry,
    output logic                            o_update_sq_en,
    output logic [`LSU_SQ_DEPTH-1:0]        o_update_sq_select,
    output logic                            o_update_sq_retry,

    output logic                            o_victim_en,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_victim_addr,
    output logic [`LSU_DC_LINE_WIDTH-1:0]   o_victim_data
);

    localparam int HALF = `LSU_DATA_WIDTH / 2;

    logic                       is_fill;
    logic                       is_store;
    logic                       is_load;
    logic                       live;
    logic [`LSU_DATA_WIDTH-1:0] ext_data;

    assign is_fill  = i_lsu_func == FILL;
    assign is_store = (i_lsu_func == SB) | (i_lsu_func == SH) | (i_lsu_func == SW);
    assign is_load  = (i_lsu_func == LB) | (i_lsu_func == LH) | (i_lsu_func == LW);
    assign live     = i_valid & ~i_flush;  // Flush hits CDB and queues only.

    always_comb begin
        case (i_lsu_func)
            LB:      ext_data = {{(`LSU_DATA_WIDTH-8){i_dc_data[7]}}, i_dc_data[7:0]};
            LH:      ext_data = {{HALF{i_dc_data[HALF-1]}}, i_dc_data[HALF-1:0]};
            default: ext_data = i_dc_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid        <= 1'b0;
            o_update_lq_en <= 1'b0;
            o_update_sq_en <= 1'b0;
            o_victim_en    <= 1'b0;
        end else begin
            o_valid        <= live & ~is_fill & ~i_retire & (i_dc_hit | is_store);
            o_update_lq_en <= live & is_load;
            o_update_sq_en <= live & is_store & i_retire;
            o_victim_en    <= i_valid & is_fill & i_dc_victim_valid & i_dc_victim_dirty;
        end
    end

    always_ff @(posedge clk) begin
        o_data             <= ext_data;
        o_addr             <= i_addr;
        o_tag              <= i_tag;
        o_update_lq_select <= i_lq_select;
        o_update_lq_retry  <= ~i_dc_hit;  // Miss sends it back to the queue.
        o_update_sq_select <= i_sq_select;
        o_update_sq_retry  <= ~i_dc_hit;
        o_victim_addr      <= i_dc_victim_addr;
        o_victim_data      <= i_dc_victim_data;
    end

endmodule

/* src/lsu_params.svh */
// Width, depth and cache geometry macros shared by the LSU RTL and its testbench.
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Datapath.
`define LSU_DATA_WIDTH       32
`define LSU_ADDR_WIDTH       32

// One-hot select widths of the load and store queues.
`define LSU_LQ_DEPTH         8
`define LSU_SQ_DEPTH         8

`define LSU_ROB_IDX_WIDTH    5

// Direct-mapped data cache geometry.
`define LSU_DC_LINE_SIZE     16
`define LSU_DC_LINE_WIDTH    (`LSU_DC_LINE_SIZE * 8)
`define LSU_DC_SETS          8
`define LSU_DC_OFFSET_WIDTH  4
`define LSU_DC_INDEX_WIDTH   3
`define LSU_DC_TAG_WIDTH     25  // Address bits above index and offset.

`define LSU_FUNC_WIDTH       3

`endif

/* src/lsu_pkg.sv */
// LSU operation and address types, imported by the pipeline stages and the testbench.
`include "lsu_params.svh"

package lsu_pkg;

    typedef enum logic [`LSU_FUNC_WIDTH-1:0] {
        LB   = 3'd0,
        LH   = 3'd1,
        LW   = 3'd2,
        SB   = 3'd3,
        SH   = 3'd4,
        SW   = 3'd5,
        FILL = 3'd6  // Line refill from memory.
    } lsu_func_t;

    typedef struct packed {
        logic [`LSU_DC_TAG_WIDTH-1:0]    tag;
        logic [`LSU_DC_INDEX_WIDTH-1:0]  index;
        logic [`LSU_DC_OFFSET_WIDTH-1:0] offset;
    } dc_addr_fields_t;

    // One address word, seen flat by the AGU and split by the cache.
    typedef union packed {
        logic [`LSU_ADDR_WIDTH-1:0] flat;
        dc_addr_fields_t            fields;
    } dc_addr_t;

endpackage

/* src/lsu_top.sv */
// LSU top level; chains address generation, data cache and execute stages.
`include "lsu_params.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,
    input  logic                            i_valid,
    input  lsu_func_t                       i_lsu_func,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_base,
    input  logic [`LSU_ADDR_WIDTH-1:0]      i_imm,
    input  logic [`LSU_ROB_IDX_WIDTH-1:0]   i_tag,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_lq_select,
    input  logic [`LSU_SQ_DEPTH-1:0]        i_sq_select,
    input  logic                            i_retire,
    input  logic [`LSU_DATA_WIDTH-1:0]      i_store_data,
    input  logic [`LSU_DC_LINE_WIDTH-1:0]   i_fill_line,

    output logic                            o_valid,
    output logic [`LSU_DATA_WIDTH-1:0]      o_data,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_addr,
    output logic [`LSU_ROB_IDX_WIDTH-1:0]   o_tag,
    output logic                            o_update_lq_en,
    output logic [`LSU_LQ_DEPTH-1:0]        o_update_lq_select,
    output logic                            o_update_lq_retry,
    output logic                            o_update_sq_en,
    output logic [`LSU_SQ_DEPTH-1:0]        o_update_sq_select,
    output logic                            o_update_sq_retry,
    output logic                            o_victim_en,
    output logic [`LSU_ADDR_WIDTH-1:0]      o_victim_addr,
    output logic [`LSU_DC_LINE_WIDTH-1:0]   o_victim_data
);

    logic                           agu_valid;
    lsu_func_t                      agu_func;
    dc_addr_t                       agu_addr;
    logic [`LSU_ROB_IDX_WIDTH-1:0]  agu_tag;
    logic [`LSU_LQ_DEPTH-1:0]       agu_lq_select;
    logic [`LSU_SQ_DEPTH-1:0]       agu_sq_select;
    logic                           agu_retire;
    logic [`LSU_DATA_WIDTH-1:0]     agu_store_data;
    logic [`LSU_DC_LINE_WIDTH-1:0]  agu_fill_line;

    logic                           dc_valid;
    lsu_func_t                      dc_func;
    dc_addr_t                       dc_addr;
    logic [`LSU_ROB_IDX_WIDTH-1:0]  dc_tag;
    logic [`LSU_LQ_DEPTH-1:0]       dc_lq_select;
    logic [`LSU_SQ_DEPTH-1:0]       dc_sq_select;
    logic                           dc_retire;
    logic                           dc_hit;
    logic [`LSU_DATA_WIDTH-1:0]     dc_data;
    logic                           dc_victim_valid;
    logic                           dc_victim_dirty;
    logic [`LSU_ADDR_WIDTH-1:0]     dc_victim_addr;
    logic [`LSU_DC_LINE_WIDTH-1:0]  dc_victim_data;

    lsu_agu lsu_agu_i (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_valid      (i_valid),
        .i_lsu_func   (i_lsu_func),
        .i_base       (i_base),
        .i_imm        (i_imm),
        .i_tag        (i_tag),
        .i_lq_select  (i_lq_select),
        .i_sq_select  (i_sq_select),
        .i_retire     (i_retire),
        .i_store_data (i_store_data),
        .i_fill_line  (i_fill_line),
        .o_valid      (agu_valid),
        .o_lsu_func   (agu_func),
        .o_addr       (agu_addr),
        .o_tag        (agu_tag),
        .o_lq_select  (agu_lq_select),
        .o_sq_select  (agu_sq_select),
        .o_retire     (agu_retire),
        .o_store_data (agu_store_data),
        .o_fill_line  (agu_fill_line)
    );

    lsu_dcache lsu_dcache_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_valid        (agu_valid),
        .i_lsu_func     (agu_func),
        .i_addr         (agu_addr),
        .i_tag          (agu_tag),
        .i_lq_select    (agu_lq_select),
        .i_sq_select    (agu_sq_select),
        .i_retire       (agu_retire),
        .i_store_data   (agu_store_data),
        .i_fill_line    (agu_fill_line),
        .o_valid        (dc_valid),
        .o_lsu_func     (dc_func),
        .o_addr         (dc_addr),
        .o_tag          (dc_tag),
        .o_lq_select    (dc_lq_select),
        .o_sq_select    (dc_sq_select),
        .o_retire       (dc_retire),
        .o_hit          (dc_hit),
        .o_data         (dc_data),
        .o_victim_valid (dc_victim_valid),
        .o_victim_dirty (dc_victim_dirty),
        .o_victim_addr  (dc_victim_addr),
        .o_victim_data  (dc_victim_data)
    );

    lsu_ex lsu_ex_i (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_valid            (dc_valid),
        .i_lsu_func         (dc_func),
        .i_lq_select        (dc_lq_select),
        .i_sq_select        (dc_sq_select),
        .i_tag              (dc_tag),
        .i_addr             (dc_addr.flat),
        .i_retire           (dc_retire),
        .i_dc_hit           (dc_hit),
        .i_dc_data          (dc_data),
        .i_dc_victim_valid  (dc_victim_valid),
        .i_dc_victim_dirty  (dc_victim_dirty),
        .i_dc_victim_addr   (dc_victim_addr),
        .i_dc_victim_data   (dc_victim_data),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_addr             (o_addr),
        .o_tag              (o_tag),
        .o_update_lq_en     (o_update_lq_en),
        .o_update_lq_select (o_update_lq_select),
        .o_update_lq_retry  (o_update_lq_retry),
        .o_update_sq_en     (o_update_sq_en),
        .o_update_sq_select (o_update_sq_select),
        .o_update_sq_retry  (o_update_sq_retry),
        .o_victim_en        (o_victim_en),
        .o_victim_addr      (o_victim_addr),
        .o_victim_data      (o_victim_data)
    );

endmodule

/* verification/lsu_checker.sv */
// Concurrent assertions on the LSU output enables, bound into every lsu_top instance.
module lsu_checker (
    input logic clk,
    input logic n_rst,
    input logic i_cdb_valid,
    input logic i_lq_en,
    input logic i_sq_en,
    input logic i_victim_en,
    input logic i_dc_valid,
    input logic i_dc_retire
);

    // Enables read low on the edge after reset is sampled.
    enables_low_in_reset: assert property (@(posedge clk)
        !n_rst |=> !(i_cdb_valid || i_lq_en || i_sq_en || i_victim_en))
        else $error("enable high while reset is applied");

    // A fill never goes out on the CDB.
    victim_not_on_cdb: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_victim_en && i_cdb_valid))
        else $error("victim enqueue together with CDB valid");

    sq_update_retired: assert property (@(posedge clk) disable iff (!n_rst)
        i_sq_en |-> $past(i_dc_valid && i_dc_retire))
        else $error("store queue update for a store that was not retired");

endmodule

bind lsu_top lsu_checker lsu_checker_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .i_cdb_valid (o_valid),
    .i_lq_en     (o_update_lq_en),
    .i_sq_en     (o_update_sq_en),
    .i_victim_en (o_victim_en),
    .i_dc_valid  (dc_valid),
    .i_dc_retire (dc_retire)
);

/* verification/lsu_clk_gen.sv */
// Testbench clock and reset source; reset is held low for the first few rising edges.
module lsu_clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic n_rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge.
    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
    end

endmodule

/* verification/lsu_tb.sv */
// Testbench for the LSU pipeline; random operations are checked against a reference cache model.
`include "lsu_params.svh"

module lsu_tb
    import lsu_pkg::*;
();

    localparam int TOTAL_OPS = 6 + 24 + 8 + 24 + 8 + 32;  // Ops of tests 1 to 5.
    localparam int DRAIN     = 3;
    localparam int TIMEOUT   = TOTAL_OPS + 5 * DRAIN + 2 + 20;
    localparam int DEPTH     = TIMEOUT + 4;

    typedef logic [`LSU_DC_TAG_WIDTH-1:0]   tag_t;
    typedef logic [`LSU_DC_INDEX_WIDTH-1:0] set_t;
    typedef logic [`LSU_DC_LINE_WIDTH-1:0]  line_t;

    typedef struct packed {
        logic [2:0]                    test;
        logic                          valid;
        logic                          chk_data;
        logic [`LSU_DATA_WIDTH-1:0]    data;
        logic [`LSU_ADDR_WIDTH-1:0]    addr;
        logic [`LSU_ROB_IDX_WIDTH-1:0] tag;
        logic                          lq_en;
        logic [`LSU_LQ_DEPTH-1:0]      lq_sel;
        logic                          lq_retry;
        logic                          sq_en;
        logic [`LSU_SQ_DEPTH-1:0]      sq_sel;
        logic                          sq_retry;
        logic                          victim_en;
        logic [`LSU_ADDR_WIDTH-1:0]    victim_addr;
        line_t                         victim_data;
    } expect_t;

    logic clk, n_rst, i_flush, i_valid, i_retire;
    lsu_func_t i_lsu_func;
    logic [`LSU_ADDR_WIDTH-1:0] i_base, i_imm, o_addr, o_victim_addr;
    logic [`LSU_ROB_IDX_WIDTH-1:0] i_tag, o_tag;
    logic [`LSU_LQ_DEPTH-1:0] i_lq_select, o_update_lq_select;
    logic [`LSU_SQ_DEPTH-1:0] i_sq_select, o_update_sq_select;
    logic [`LSU_DATA_WIDTH-1:0] i_store_data, o_data;
    line_t i_fill_line, o_victim_data;
    logic o_valid, o_update_lq_en, o_update_lq_retry;
    logic o_update_sq_en, o_update_sq_retry, o_victim_en;

    // Reference cache state.
    tag_t ref_tag [`LSU_DC_SETS];
    line_t ref_line [`LSU_DC_SETS];
    logic [`LSU_DC_SETS-1:0] ref_valid, ref_dirty;

    expect_t exp_tab [DEPTH];
    logic flush_sched [DEPTH];
    int cycle = 0;
    int checks = 0;
    int err_by_test [8];
    int ops_in_test;
    logic [2:0] cur_test;
    logic [31:0] lfsr;

    lsu_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) lsu_clk_gen_i (.clk(clk), .n_rst(n_rst));

    lsu_top lsu_top_i (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic fb;
        int k;
        r = '0;
        for (k = 0; k < n; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1.
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic line_t rand_line();
        line_t l;
        int k;
        for (k = 0; k < `LSU_DC_LINE_WIDTH / 32; k++) l[k*32 +: 32] = take_bits(32);
        return l;
    endfunction

    function automatic dc_addr_t make_addr(input tag_t t, input set_t s, input logic [3:0] off);
        dc_addr_t a;
        a.fields.tag    = t;
        a.fields.index  = s;
        a.fields.offset = off;
        return a;
    endfunction

    // Expected outputs of one operation; updates the model cache as the op passes.
    function automatic expect_t model_op(input lsu_func_t func, input dc_addr_t a,
                                         input logic retire, input logic [31:0] sdata,
                                         input line_t fill, input logic flush,
                                         input logic [4:0] rtag, input logic [7:0] lqs,
                                         input logic [7:0] sqs);
        expect_t e;
        set_t idx;
        logic [3:0] off;
        logic hit, is_load, is_store;
        logic [31:0] raw;
        int k, nbytes;
        e        = '0;
        idx      = a.fields.index;
        off      = a.fields.offset;
        hit      = ref_valid[idx] && (ref_tag[idx] == a.fields.tag);
        is_load  = (func == LB) || (func == LH) || (func == LW);
        is_store = (func == SB) || (func == SH) || (func == SW);
        raw      = '0;
        for (k = 0; k < 4; k++) begin
            if (int'(off) + k < `LSU_DC_LINE_SIZE) begin
                raw[k*8 +: 8] = ref_line[idx][(int'(off) + k)*8 +: 8];
            end
        end
        case (func)
            LB:      e.data = {{24{raw[7]}}, raw[7:0]};
            LH:      e.data = {{16{raw[15]}}, raw[15:0]};
            default: e.data = raw;
        endcase
        e.test     = cur_test;
        e.addr     = a.flat;
        e.tag      = rtag;
        e.lq_sel   = lqs;
        e.sq_sel   = sqs;
        e.valid    = !flush && (func != FILL) && !retire && (hit || is_store);
        e.chk_data = e.valid && is_load;
        e.lq_en    = !flush && is_load;
        e.lq_retry = !hit;
        e.sq_en    = !flush && is_store && retire;
        e.sq_retry = !hit;
        if (func == FILL) begin
            e.victim_en   = ref_valid[idx] && ref_dirty[idx];  // Flush does not stop it.
            e.victim_addr = {ref_tag[idx], idx, 4'h0};
            e.victim_data = ref_line[idx];
            ref_tag[idx]   = a.fields.tag;
            ref_line[idx]  = fill;
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
        end else if (is_store && retire && hit) begin
            nbytes = (func == SB) ? 1 : (func == SH) ? 2 : 4;
            for (k = 0; k < nbytes; k++) ref_line[idx][(int'(off) + k)*8 +: 8] = sdata[k*8 +: 8];
            ref_dirty[idx] = 1'b1;
        end
        return e;
    endfunction

    task automatic issue(input lsu_func_t func, input dc_addr_t addr, input logic retire,
                         input logic [31:0] sdata, input line_t fill, input logic flush);
        logic [31:0] base;
        logic [4:0] rtag;
        logic [7:0] lqs, sqs;
        @(negedge clk);
        base = take_bits(32);
        rtag = 5'(take_bits(5));
        lqs  = 8'b1 << take_bits(3);
        sqs  = 8'b1 << take_bits(3);
        exp_tab[cycle] = model_op(func, addr, retire, sdata, fill, flush, rtag, lqs, sqs);
        flush_sched[cycle + 2] = flush;  // Op reaches the execute stage two cycles later.
        i_flush      = flush_sched[cycle];
        i_valid      = 1'b1;
        i_lsu_func   = func;
        i_base       = base;
        i_imm        = addr.flat - base;
        i_tag        = rtag;
        i_lq_select  = lqs;
        i_sq_select  = sqs;
        i_retire     = retire;
        i_store_data = sdata;
        i_fill_line  = fill;
        ops_in_test++;
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        exp_tab[cycle] = '0;
        i_flush = flush_sched[cycle];
        i_valid = 1'b0;
    endtask

    task automatic rand_load(input set_t s, input tag_t t, input logic flush);
        lsu_func_t f;
        logic [3:0] off;
        logic [1:0] pick;
        pick = 2'(take_bits(2) % 3);
        case (pick)
            2'd0: begin
                f = LB;
                off = 4'(take_bits(4));
            end
            2'd1: begin
                f = LH;
                off = {3'(take_bits(3)), 1'b0};
            end
            default: begin
                f = LW;
                off = {2'(take_bits(2)), 2'b00};
            end
        endcase
        issue(f, make_addr(t, s, off), 1'b0, '0, '0, flush);
    endtask

    task automatic rand_store(input set_t s, input tag_t t, input logic retire,
                              input logic flush, output dc_addr_t a);
        lsu_func_t f;
        logic [3:0] off;
        logic [1:0] pick;
        logic [31:0] d;
        pick = 2'(take_bits(2) % 3);
        case (pick)
            2'd0: begin
                f = SB;
                off = 4'(take_bits(4));
            end
            2'd1: begin
                f = SH;
                off = {3'(take_bits(3)), 1'b0};
            end
            default: begin
                f = SW;
                off = {2'(take_bits(2)), 2'b00};
            end
        endcase
        d = take_bits(32);
        a = make_addr(t, s, off);
        issue(f, a, retire, d, '0, flush);
    endtask

    task automatic finish_test(input string name);
        repeat (DRAIN) idle_cycle();
        @(posedge clk);  // Last compare of this test is done.
        $display("test %0d %s: %0d ops, %0d errors", cur_test, name, ops_in_test,
                 err_by_test[cur_test]);
        cur_test = cur_test + 3'd1;
        ops_in_test = 0;
    endtask

    task automatic check_field(input string what, input logic [127:0] got,
                               input logic [127:0] want, input logic [2:0] test);
        checks++;
        assert (got === want) else begin
            $display("mismatch at %0t: test %0d %s is %0h, expected %0h",
                     $time, test, what, got, want);
            err_by_test[test]++;
        end
    endtask

    task automatic check_outputs(input expect_t e);
        check_field("o_valid", 128'(o_valid), 128'(e.valid), e.test);
        check_field("o_update_lq_en", 128'(o_update_lq_en), 128'(e.lq_en), e.test);
        check_field("o_update_sq_en", 128'(o_update_sq_en), 128'(e.sq_en), e.test);
        check_field("o_victim_en", 128'(o_victim_en), 128'(e.victim_en), e.test);
        if (e.valid) begin
            check_field("o_addr", 128'(o_addr), 128'(e.addr), e.test);
            check_field("o_tag", 128'(o_tag), 128'(e.tag), e.test);
        end
        if (e.chk_data) check_field("o_data", 128'(o_data), 128'(e.data), e.test);
        if (e.lq_en) begin
            check_field("o_update_lq_select", 128'(o_update_lq_select), 128'(e.lq_sel), e.test);
            check_field("o_update_lq_retry", 128'(o_update_lq_retry), 128'(e.lq_retry), e.test);
        end
        if (e.sq_en) begin
            check_field("o_update_sq_select", 128'(o_update_sq_select), 128'(e.sq_sel), e.test);
            check_field("o_update_sq_retry", 128'(o_update_sq_retry), 128'(e.sq_retry), e.test);
        end
        if (e.victim_en) begin
            check_field("o_victim_addr", 128'(o_victim_addr), 128'(e.victim_addr), e.test);
            check_field("o_victim_data", o_victim_data, e.victim_data, e.test);
        end
    endtask

    // Outputs of the op driven three falling edges ago.
    always @(negedge clk) begin
        if (cycle >= 3) check_outputs(exp_tab[cycle - 3]);
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int n, total;
        set_t s;
        tag_t t;
        line_t line;
        dc_addr_t a;
        logic [2:0] kind;
        logic fl;
        lfsr = 32'hf8aa;
        {i_flush, i_valid, i_retire} = '0;
        {i_base, i_imm, i_tag, i_lq_select, i_sq_select, i_store_data, i_fill_line} = '0;
        i_lsu_func = LB;
        ref_valid = '0;
        ref_dirty = '0;
        for (n = 0; n < DEPTH; n++) begin
            exp_tab[n] = '0;
            flush_sched[n] = 1'b0;
        end
        for (n = 0; n < 8; n++) err_by_test[n] = 0;
        cur_test = 3'd1;
        ops_in_test = 0;
        wait (n_rst === 1'b1);

        // Sets 6 and 7 stay empty for the miss test.
        for (n = 0; n < 6; n++) begin
            t = tag_t'(take_bits(`LSU_DC_TAG_WIDTH));
            line = rand_line();
            issue(FILL, make_addr(t, set_t'(n), 4'h0), 1'b0, '0, line, 1'b0);
        end
        for (n = 0; n < 24; n++) begin
            s = set_t'(take_bits(3) % 6);
            rand_load(s, ref_tag[s], 1'b0);
        end
        finish_test("fill then load");

        for (n = 0; n < 8; n++) begin
            s = set_t'(6 + take_bits(1));
            rand_load(s, tag_t'(take_bits(`LSU_DC_TAG_WIDTH)), 1'b0);
        end
        finish_test("load miss");

        for (n = 0; n < 8; n++) begin
            s = set_t'(take_bits(3));
            rand_store(s, tag_t'(take_bits(`LSU_DC_TAG_WIDTH)), 1'b0, 1'b0, a);
        end
        for (n = 0; n < 8; n++) begin
            s = set_t'(take_bits(2));  // Only sets 0 to 3 get dirty.
            rand_store(s, ref_tag[s], 1'b1, 1'b0, a);
            a.fields.offset[1:0] = 2'b00;
            issue(LW, a, 1'b0, '0, '0, 1'b0);
        end
        finish_test("store merge");

        for (n = 0; n < 8; n++) begin
            t = tag_t'(take_bits(`LSU_DC_TAG_WIDTH));
            line = rand_line();
            issue(FILL, make_addr(t, set_t'(n), 4'h0), 1'b0, '0, line, 1'b0);
        end
        finish_test("victim");

        for (n = 0; n < 32; n++) begin
            s = set_t'(take_bits(3));
            if (take_bits(1) != 0) begin
                t = ref_tag[s];
            end else begin
                t = tag_t'(take_bits(`LSU_DC_TAG_WIDTH));
            end
            kind = 3'(take_bits(3));
            fl = 1'(take_bits(1));
            case (kind)
                3'd3, 3'd4, 3'd5: rand_store(s, t, 1'(take_bits(1)), fl, a);
                3'd6: begin
                    line = rand_line();
                    issue(FILL, make_addr(t, s, 4'h0), 1'b0, '0, line, fl);
                end
                default: rand_load(s, t, fl);
            endcase
        end
        finish_test("flush");

        total = 0;
        for (n = 0; n < 8; n++) total += err_by_test[n];
        $display("summary: %0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
